/* common/fetch_pkg.sv */
package fetch_pkg;

    // instruction parcels
    localparam int PARCEL_W = 16;

    typedef logic [PARCEL_W-1:0] parcel_t;

    // lanes of the fetch queue
    localparam int N_LANES    = 2;
    localparam int LANE_DEPTH = 2;
    localparam int LANE_PTR_W = $clog2(LANE_DEPTH);

    typedef logic [1:0] lane_cnt_t; // 0 .. LANE_DEPTH

    // whole queue
    localparam int QUEUE_SLOTS      = N_LANES * LANE_DEPTH;
    localparam int SLOT_CNT_W       = $clog2(QUEUE_SLOTS + 1);
    localparam int RESERVED_PARCELS = 2; // room for a response still in flight
    localparam int MAX_VACANCY      = 2; // one full word

    typedef logic [1:0] vacancy_t;

    // first fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // low opcode bits of a 32-bit instruction, anything else is compressed
    localparam logic [1:0] OPC_FULL = 2'b11;

endpackage

/* common/ibus_pkg.sv */
package ibus_pkg;

    localparam int XLEN = 32;

    // access size code on the instruction bus
    typedef logic [1:0] acc_t;

    localparam acc_t ACC_1B = 2'd0;
    localparam acc_t ACC_2B = 2'd1;
    localparam acc_t ACC_4B = 2'd2;

    // one bus word, seen whole or as two halfword parcels
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [XLEN/2-1:0] hi;
            logic [XLEN/2-1:0] lo; // a 2-byte response lands here
        } parcels;
    } bus_word_t;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    // instruction bus
    output logic                        o_ibus_req,
    output logic [ibus_pkg::XLEN-1:0]   o_ibus_addr,
    output ibus_pkg::acc_t              o_ibus_acc,
    input  logic                        i_ibus_resp,
    input  ibus_pkg::bus_word_t         i_ibus_rdata,
    // jumps from the consumer
    input  logic                        i_redirect,
    input  logic [ibus_pkg::XLEN-1:0]   i_redirect_pc,
    // instruction output
    output logic                        o_instr_valid,
    output logic [31:0]                 o_instr,
    output logic [ibus_pkg::XLEN-1:0]   o_instr_pc,
    output logic                        o_instr_compressed,
    input  logic                        i_instr_ready
);
    import ibus_pkg::*;
    import fetch_pkg::*;

    logic      fill_valid;
    logic      fill_half;
    bus_word_t fill_word;
    vacancy_t  vacancy;

    logic      push [N_LANES];
    parcel_t   push_data [N_LANES];
    logic      pop [N_LANES];
    parcel_t   head [N_LANES];
    lane_cnt_t lane_cnt [N_LANES];

    fetch_requester requester_inst (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_vacancy     (vacancy),
        .i_ibus_resp   (i_ibus_resp),
        .i_ibus_rdata  (i_ibus_rdata),
        .o_ibus_req    (o_ibus_req),
        .o_ibus_addr   (o_ibus_addr),
        .o_ibus_acc    (o_ibus_acc),
        .o_fill_valid  (fill_valid),
        .o_fill_half   (fill_half),
        .o_fill_word   (fill_word)
    );

    lane_splitter splitter_inst (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_redirect   (i_redirect),
        .i_fill_valid (fill_valid),
        .i_fill_half  (fill_half),
        .i_fill_word  (fill_word),
        .i_lane_cnt   (lane_cnt),
        .o_push       (push),
        .o_push_data  (push_data),
        .o_vacancy    (vacancy)
    );

    generate
        for (genvar g = 0; g < N_LANES; g++) begin : g_lane
            parcel_lane lane_inst (
                .i_clk   (i_clk),
                .i_rstn  (i_rstn),
                .i_clear (i_redirect), // queue flush on a jump
                .i_push  (push[g]),
                .i_data  (push_data[g]),
                .i_pop   (pop[g]),
                .o_head  (head[g]),
                .o_count (lane_cnt[g])
            );
        end
    endgenerate

    instr_assembler assembler_inst (
        .i_clk              (i_clk),
        .i_rstn             (i_rstn),
        .i_redirect         (i_redirect),
        .i_redirect_pc      (i_redirect_pc),
        .i_head             (head),
        .i_lane_cnt         (lane_cnt),
        .i_instr_ready      (i_instr_ready),
        .o_pop              (pop),
        .o_instr_valid      (o_instr_valid),
        .o_instr            (o_instr),
        .o_instr_pc         (o_instr_pc),
        .o_instr_compressed (o_instr_compressed)
    );

endmodule

/* list.f */
common/ibus_pkg.sv
common/fetch_pkg.sv
prefetch/parcel_lane.sv
prefetch/fetch_requester.sv
prefetch/lane_splitter.sv
prefetch/instr_assembler.sv
hw/fetch_unit.sv
tests/ibus_memory_model.sv
tests/tb_fetch_unit.sv

/* prefetch/fetch_requester.sv */
`timescale 1ns/1ps

module fetch_requester (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_redirect,
    input  logic [ibus_pkg::XLEN-1:0]   i_redirect_pc,
    input  fetch_pkg::vacancy_t         i_vacancy,
    input  logic                        i_ibus_resp,
    input  ibus_pkg::bus_word_t         i_ibus_rdata,
    output logic                        o_ibus_req,
    output logic [ibus_pkg::XLEN-1:0]   o_ibus_addr,
    output ibus_pkg::acc_t              o_ibus_acc,
    output logic                        o_fill_valid,
    output logic                        o_fill_half,
    output ibus_pkg::bus_word_t         o_fill_word
);
    import ibus_pkg::*;
    import fetch_pkg::*;

    logic [XLEN-1:0] addr_q;     // next fetch address
    logic            run_q;      // low for the first cycle out of reset
    logic            pending_q;  // a request is on the bus
    logic            live_q;     // its response is still wanted
    acc_t            pend_acc_q; // size of the outstanding request

    logic            bus_busy;
    logic            launch;
    acc_t            acc;
    logic [XLEN-1:0] step;

    // the response cycle frees the bus for a back-to-back launch
    assign bus_busy = pending_q && !i_ibus_resp;

    assign launch = run_q && !bus_busy && !i_redirect && (i_vacancy != '0);

    // halfword fetch to realign, or when only one slot is spare
    always_comb begin
        if (addr_q[1] || i_vacancy == vacancy_t'(1)) begin
            acc = ACC_2B;
        end else begin
            acc = ACC_4B;
        end
    end

    assign step = (acc == ACC_2B) ? XLEN'(2) : XLEN'(4);

    assign o_ibus_req  = launch;
    assign o_ibus_addr = addr_q;
    assign o_ibus_acc  = acc;

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            addr_q <= RESET_PC;
        end else if (i_redirect) begin
            addr_q <= i_redirect_pc;
        end else if (launch) begin
            addr_q <= addr_q + step;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            run_q     <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (launch) begin
                pending_q <= 1'b1;
            end else if (i_ibus_resp) begin
                pending_q <= 1'b0;
            end
        end
    end

    // a jump cancels whatever is still in flight
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            live_q <= 1'b0;
        end else if (i_redirect) begin
            live_q <= 1'b0;
        end else if (launch) begin
            live_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (launch) begin
            pend_acc_q <= acc;
        end
    end

    assign o_fill_valid = i_ibus_resp && live_q;
    assign o_fill_half  = (pend_acc_q == ACC_2B);
    assign o_fill_word  = i_ibus_rdata;

endmodule

/* prefetch/instr_assembler.sv */
`timescale 1ns/1ps

module instr_assembler (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_redirect,
    input  logic [ibus_pkg::XLEN-1:0]   i_redirect_pc,
    input  fetch_pkg::parcel_t          i_head [fetch_pkg::N_LANES],
    input  fetch_pkg::lane_cnt_t        i_lane_cnt [fetch_pkg::N_LANES],
    input  logic                        i_instr_ready,
    output logic                        o_pop [fetch_pkg::N_LANES],
    output logic                        o_instr_valid,
    output logic [31:0]                 o_instr,
    output logic [ibus_pkg::XLEN-1:0]   o_instr_pc,
    output logic                        o_instr_compressed
);
    import ibus_pkg::*;
    import fetch_pkg::*;

    logic            rsel_q; // lane holding the oldest parcel
    logic [XLEN-1:0] pc_q;

    parcel_t         lo_parcel;
    parcel_t         hi_parcel;
    logic            lo_present;
    logic            hi_present;
    logic            compressed;
    logic            fire;

    assign lo_parcel  = i_head[rsel_q];
    assign hi_parcel  = i_head[!rsel_q];
    assign lo_present = (i_lane_cnt[rsel_q] != '0);
    assign hi_present = (i_lane_cnt[!rsel_q] != '0);

    // length comes from the opcode bits of the first parcel
    assign compressed = (lo_parcel[1:0] != OPC_FULL);

    // a jump cycle never hands anything out
    assign o_instr_valid = !i_redirect && lo_present && (compressed || hi_present);

    // upper half is junk for a compressed instruction
    assign o_instr            = {hi_parcel, lo_parcel};
    assign o_instr_pc         = pc_q;
    assign o_instr_compressed = compressed;

    assign fire = o_instr_valid && i_instr_ready;

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            o_pop[i] = fire && (i == int'(rsel_q) || !compressed);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            rsel_q <= 1'b0;
            pc_q   <= RESET_PC;
        end else if (i_redirect) begin
            rsel_q <= 1'b0;
            pc_q   <= i_redirect_pc;
        end else if (fire) begin
            rsel_q <= rsel_q ^ compressed; // single pop moves to the other lane
            pc_q   <= pc_q + (compressed ? XLEN'(2) : XLEN'(4));
        end
    end

endmodule

/* prefetch/lane_splitter.sv */
`timescale 1ns/1ps

module lane_splitter (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_redirect,
    input  logic                 i_fill_valid,
    input  logic                 i_fill_half,
    input  ibus_pkg::bus_word_t  i_fill_word,
    input  fetch_pkg::lane_cnt_t i_lane_cnt [fetch_pkg::N_LANES],
    output logic                 o_push [fetch_pkg::N_LANES],
    output fetch_pkg::parcel_t   o_push_data [fetch_pkg::N_LANES],
    output fetch_pkg::vacancy_t  o_vacancy
);
    import fetch_pkg::*;

    logic                  wsel_q; // lane that takes the next parcel
    logic [SLOT_CNT_W-1:0] free_slots;

    // low parcel to the selected lane, high parcel to the other one
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            o_push[i]      = i_fill_valid && (!i_fill_half || i == int'(wsel_q));
            o_push_data[i] = (i == int'(wsel_q)) ? i_fill_word.parcels.lo
                                                 : i_fill_word.parcels.hi;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            wsel_q <= 1'b0;
        end else if (i_redirect) begin
            wsel_q <= 1'b0;
        end else if (i_fill_valid && i_fill_half) begin
            wsel_q <= !wsel_q; // odd parcel count shifts the pairing
        end
    end

    always_comb begin
        free_slots = SLOT_CNT_W'(QUEUE_SLOTS);
        for (int i = 0; i < N_LANES; i++) begin
            free_slots = free_slots - SLOT_CNT_W'(i_lane_cnt[i]);
        end
    end

    // keep a response's worth of slots back, report the rest
    always_comb begin
        if (free_slots <= SLOT_CNT_W'(RESERVED_PARCELS)) begin
            o_vacancy = '0;
        end else begin
            o_vacancy = vacancy_t'(free_slots - SLOT_CNT_W'(RESERVED_PARCELS));
        end
    end

endmodule

/* prefetch/parcel_lane.sv */
`timescale 1ns/1ps

module parcel_lane (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_clear,
    input  logic                 i_push,
    input  fetch_pkg::parcel_t   i_data,
    input  logic                 i_pop,
    output fetch_pkg::parcel_t   o_head,
    output fetch_pkg::lane_cnt_t o_count
);
    import fetch_pkg::*;

    parcel_t               mem [LANE_DEPTH];
    logic [LANE_PTR_W-1:0] wr_ptr_q;
    logic [LANE_PTR_W-1:0] rd_ptr_q;
    lane_cnt_t             count_q;

    // wrapping pointer increment
    function automatic logic [LANE_PTR_W-1:0] ptr_next(input logic [LANE_PTR_W-1:0] ptr);
        if (ptr == LANE_PTR_W'(LANE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_push && !i_clear) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (i_clear) begin
            // flush beats any push or pop in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (i_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_q + lane_cnt_t'(i_push) - lane_cnt_t'(i_pop);
        end
    end

    assign o_head  = mem[rd_ptr_q]; // visible before the pop edge
    assign o_count = count_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert \
        --timescale 1ns/1ps \
        --top-module tb_fetch_unit \
        -Mdir obj_dir -o sim_fetch_unit \
        -f list.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_fetch_unit 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tests/ibus_memory_model.sv */
`timescale 1ns/1ps

module ibus_memory_model (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_req,
    input  logic [ibus_pkg::XLEN-1:0] i_addr,
    input  ibus_pkg::acc_t            i_acc,
    output logic                      o_resp,
    output ibus_pkg::bus_word_t       o_rdata
);
    import ibus_pkg::*;

    localparam int IMAGE_PARCELS = 256; // 512 bytes, addresses wrap

    logic [15:0]     image [IMAGE_PARCELS];
    integer          seed;
    logic [31:0]     rnd;
    logic            req_seen;
    logic [XLEN-1:0] req_addr;
    acc_t            req_acc;
    logic [7:0]      idx;
    int              delay;
    logic            resp_q = 1'b0;
    bus_word_t       rdata_q = '0;

    // random image, half of the parcels open a 32-bit instruction
    initial begin
        seed = 32'h503584ae;
        for (int i = 0; i < IMAGE_PARCELS; i++) begin
            rnd = $random(seed);
            rnd[1:0] = rnd[16] ? 2'b11 : {1'b0, rnd[0]};
            image[i] = rnd[15:0];
        end
    end

    // strobe capture, address kept until the next launch
    always @(posedge i_clk) begin
        req_seen <= i_rstn && i_req;
        if (i_req) begin
            req_addr <= i_addr;
            req_acc  <= i_acc;
        end
    end

    // response driven between edges, 1 to 4 cycles after the strobe
    always @(negedge i_clk) begin
        resp_q = 1'b0;
        if (!i_rstn) begin
            delay = 0;
        end else begin
            if (req_seen) begin
                delay = 1 + ($random(seed) & 3);
            end
            if (delay != 0) begin
                delay = delay - 1;
                if (delay == 0) begin
                    idx = req_addr[8:1];
                    resp_q = 1'b1;
                    rdata_q.parcels.lo = image[idx];
                    rdata_q.parcels.hi = (req_acc == ACC_2B) ? 16'hffff : image[idx + 8'd1];
                end
            end
        end
    end

    assign o_resp  = resp_q;
    assign o_rdata = rdata_q;

endmodule

/* tests/tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit;
    import ibus_pkg::*;
    import fetch_pkg::*;

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 8;
    localparam int N_INSTR          = 2000;
    localparam int CYCLES_PER_INSTR = 12;

    logic            clk;
    logic            rstn;
    logic            ibus_req;
    logic [XLEN-1:0] ibus_addr;
    acc_t            ibus_acc;
    logic            ibus_resp;
    bus_word_t       ibus_rdata;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] instr_pc;
    logic            instr_compressed;
    logic            instr_ready;

    integer          seed;
    int              accepted;
    logic [XLEN-1:0] model_pc;    // pc of the next instruction to accept
    logic [XLEN-1:0] next_addr;   // where the next launch has to go
    logic            outstanding; // seen on the bus, no response yet
    logic            fire;

    fetch_unit fetch_unit_inst (
        .i_clk              (clk),
        .i_rstn             (rstn),
        .o_ibus_req         (ibus_req),
        .o_ibus_addr        (ibus_addr),
        .o_ibus_acc         (ibus_acc),
        .i_ibus_resp        (ibus_resp),
        .i_ibus_rdata       (ibus_rdata),
        .i_redirect         (redirect),
        .i_redirect_pc      (redirect_pc),
        .o_instr_valid      (instr_valid),
        .o_instr            (instr),
        .o_instr_pc         (instr_pc),
        .o_instr_compressed (instr_compressed),
        .i_instr_ready      (instr_ready)
    );

    ibus_memory_model memory_inst (
        .i_clk   (clk),
        .i_rstn  (rstn),
        .i_req   (ibus_req),
        .i_addr  (ibus_addr),
        .i_acc   (ibus_acc),
        .o_resp  (ibus_resp),
        .o_rdata (ibus_rdata)
    );

    function automatic logic [15:0] image_at(input logic [XLEN-1:0] pc);
        return memory_inst.image[pc[8:1]];
    endfunction

    // length rule, low bits 11 open a 32-bit instruction
    function automatic logic exp_compressed(input logic [XLEN-1:0] pc);
        logic [15:0] parcel;
        parcel = image_at(pc);
        return parcel[1:0] != 2'b11;
    endfunction

    task automatic end_in_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string what);
        $display("[FAIL] %0t: %s", $time, what);
        end_in_failure();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign fire = instr_valid && instr_ready;

    // reference model and bus bookkeeping
    always @(posedge clk) begin
        if (!rstn) begin
            accepted    <= 0;
            model_pc    <= RESET_PC;
            next_addr   <= RESET_PC;
            outstanding <= 1'b0;
        end else begin
            if (ibus_req) begin
                outstanding <= 1'b1;
            end else if (ibus_resp) begin
                outstanding <= 1'b0;
            end
            if (redirect) begin
                next_addr <= redirect_pc;
                model_pc  <= redirect_pc;
            end else begin
                if (ibus_req) begin
                    next_addr <= ibus_addr + ((ibus_acc == ACC_2B) ? 32'd2 : 32'd4);
                end
                if (fire) begin
                    model_pc <= model_pc + (exp_compressed(model_pc) ? 32'd2 : 32'd4);
                end
            end
            if (fire) begin
                accepted <= accepted + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rstn && $past(!rstn) |-> !ibus_req && !instr_valid)
        else flag_mismatch("request or valid while in reset");
    a_req_addr: assert property (@(posedge clk) disable iff (!rstn) ibus_req |-> ibus_addr == next_addr)
        else flag_mismatch($sformatf("request to %h, expected %h", ibus_addr, next_addr));
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        ibus_req |-> !outstanding || ibus_resp)
        else flag_mismatch("second request while one is outstanding");
    a_halfword_acc: assert property (@(posedge clk) disable iff (!rstn)
        ibus_req && ibus_addr[1] |-> ibus_acc == ACC_2B)
        else flag_mismatch($sformatf("access code %0d at odd halfword %h", ibus_acc, ibus_addr));
    a_redirect_idle: assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> !instr_valid && !ibus_req)
        else flag_mismatch("valid or request in a redirect cycle");
    a_instr_pc: assert property (@(posedge clk) disable iff (!rstn) fire |-> instr_pc == model_pc)
        else flag_mismatch($sformatf("instr pc %h, expected %h", instr_pc, model_pc));
    a_instr_len: assert property (@(posedge clk) disable iff (!rstn)
        fire |-> instr_compressed == exp_compressed(model_pc))
        else flag_mismatch($sformatf("wrong length flag at pc %h", model_pc));
    a_instr_low: assert property (@(posedge clk) disable iff (!rstn)
        fire |-> instr[15:0] == image_at(model_pc))
        else flag_mismatch($sformatf("low parcel %h at pc %h, expected %h",
                                     instr[15:0], model_pc, image_at(model_pc)));
    a_instr_high: assert property (@(posedge clk) disable iff (!rstn)
        fire && !instr_compressed |-> instr[31:16] == image_at(model_pc + 32'd2))
        else flag_mismatch($sformatf("high parcel %h at pc %h, expected %h",
                                     instr[31:16], model_pc, image_at(model_pc + 32'd2)));
    // stalled output holds until taken or flushed by a jump
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid && !instr_ready |=> redirect || (instr_valid && $stable(instr_pc)
            && $stable(instr_compressed) && $stable(instr[15:0])
            && (instr_compressed || $stable(instr[31:16]))))
        else flag_mismatch("output changed while stalled");

    initial begin
        repeat (RESET_CYCLES + N_INSTR * CYCLES_PER_INSTR) @(posedge clk);
        $display("timeout: only %0d of %0d instructions accepted", accepted, N_INSTR);
        end_in_failure();
    end

    initial begin
        seed        = 32'h503584ae;
        rstn        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        instr_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        while (accepted < N_INSTR) begin
            @(negedge clk);
            instr_ready = ($random(seed) & 3) != 0; // stalls about a quarter of the time
            if (!redirect && ($random(seed) & 31) == 0) begin
                redirect    = 1'b1;
                redirect_pc = $random(seed) & 32'h0000_03fe;
            end else begin
                redirect = 1'b0;
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
